// ==== hw/alu_pkg.sv ====
package alu_pkg;

    localparam int slice_width = 4;
    localparam int slice_count = 2;
    localparam int word_width  = slice_width * slice_count;

    // raw control words, bits that the operation ignores are left at zero
    typedef enum logic [4:0] {
        ADD   = 5'b00000, // becomes add-with-carry once carry_in is set
        SUB   = 5'b11000, // carry_out high means no borrow
        XOR   = 5'b00100,
        XNOR  = 5'b01100,
        COMP  = 5'b01000, // A-B-1 so carry_out means A>B and all ones means A==B
        AND   = 5'b00101,
        OR    = 5'b00110,
        RSHFT = 5'b00111  // B moves right by one and carry_in fills the MSB
    } alu_cmd_e;

    // field view of the same five bits
    typedef struct packed {
        logic       carry_in;      // carry into bit 0, or the shift-in bit
        logic       b_inv;         // invert the second operand
        logic       carry_disable; // mask carries so sel 00 gives a plain xor
        logic [1:0] sel;           // 00 sum or xor, 01 and, 10 or, 11 shift
    } alu_ctrl_t;

    typedef union packed {
        alu_cmd_e  cmd;
        alu_ctrl_t ctrl;
    } alu_ctrl_u;

    typedef struct packed {
        logic [slice_width-1:0] d1;
        logic [slice_width-1:0] d2;
        alu_ctrl_u              ctrl;
    } slice_args_t;

    typedef struct packed {
        logic                   carry_out;
        logic [slice_width-1:0] res;
    } slice_ret_t;

endpackage

// ==== hw/alu_slice_if.sv ====
interface alu_slice_if;

    alu_pkg::slice_args_t args; // operand nibbles and the control word for this slice
    alu_pkg::slice_ret_t  ret;  // result nibble and carry coming back

    // the word level drives the operands and control of each slice
    modport master (
        output args,
        input  ret
    );

    // the slice reads its arguments and answers with its result
    modport slice (
        input  args,
        output ret
    );

endinterface

// ==== hw/full_adder.sv ====
module full_adder (
    input  logic               d1,
    input  logic               d2,
    input  logic               carry_in,
    input  logic               direct_in,
    input  alu_pkg::alu_ctrl_u ctrl,
    output logic               res,
    output logic               gen,
    output logic               prop,
    output logic               d2_inv
);

    logic carry_eff;

    assign d2_inv = d2 ^ ctrl.ctrl.b_inv; // becomes ~B for SUB, COMP and XNOR

    assign gen  = d1 & d2_inv;
    assign prop = d1 ^ d2_inv;

    // logic operations run with carry_disable set, which leaves the bare xor of the operands
    assign carry_eff = carry_in & ~ctrl.ctrl.carry_disable;

    always_comb begin
        case (ctrl.ctrl.sel)
            2'b00:   res = prop ^ carry_eff; // sum, or xor and xnor with the carry masked
            2'b01:   res = d1 & d2_inv;
            2'b10:   res = d1 | d2_inv;
            default: res = direct_in;        // bit shifted in from the cell above
        endcase
    end

endmodule

// ==== hw/carry_gen.sv ====
module carry_gen (
    input  logic       carry_in,
    input  logic [3:0] gen,
    input  logic [3:0] prop,
    output logic [3:1] carry,
    output logic       carry_out
);

    // each carry is a flat sum of products over all lower bits, so nothing ripples

    assign carry[1] = gen[0]
                    | (prop[0] & carry_in);

    assign carry[2] = gen[1]
                    | (prop[1] & gen[0])
                    | (prop[1] & prop[0] & carry_in);

    assign carry[3] = gen[2]
                    | (prop[2] & gen[1])
                    | (prop[2] & prop[1] & gen[0])
                    | (prop[2] & prop[1] & prop[0] & carry_in);

    assign carry_out = gen[3]
                     | (prop[3] & gen[2])
                     | (prop[3] & prop[2] & gen[1])
                     | (prop[3] & prop[2] & prop[1] & gen[0])
                     | (prop[3] & prop[2] & prop[1] & prop[0] & carry_in);

endmodule

// ==== hw/alu_slice.sv ====
module alu_slice (
    alu_slice_if.slice bus
);

    logic [alu_pkg::slice_width-1:0] gen;
    logic [alu_pkg::slice_width-1:0] prop;
    logic [alu_pkg::slice_width-1:0] carry;
    logic [alu_pkg::slice_width:0]   d2_inv;    // top bit is the shift-in from outside
    logic [alu_pkg::slice_width-1:0] res_bits;
    logic                            carry_in;
    logic                            carry_out;

    assign carry_in = bus.args.ctrl.ctrl.carry_in;

    assign carry[0] = carry_in;
    assign d2_inv[alu_pkg::slice_width] = carry_in; // for RSHFT the carry bit is the new MSB

    carry_gen u_carry_gen (
        .carry_in  (carry_in),
        .gen       (gen),
        .prop      (prop),
        .carry     (carry[alu_pkg::slice_width-1:1]),
        .carry_out (carry_out)
    );

    // the direct input of each cell is the possibly inverted B of the cell above it
    for (genvar i = 0; i < alu_pkg::slice_width; i++) begin : g_bit
        full_adder u_bit (
            .d1        (bus.args.d1[i]),
            .d2        (bus.args.d2[i]),
            .carry_in  (carry[i]),
            .direct_in (d2_inv[i+1]),
            .ctrl      (bus.args.ctrl),
            .res       (res_bits[i]),
            .gen       (gen[i]),
            .prop      (prop[i]),
            .d2_inv    (d2_inv[i])
        );
    end

    assign bus.ret = '{carry_out: carry_out, res: res_bits};

endmodule

// ==== hw/alu_word.sv ====
module alu_word (
    input  alu_pkg::alu_ctrl_u              cmd,
    input  logic [alu_pkg::word_width-1:0]  d1,
    input  logic [alu_pkg::word_width-1:0]  d2,
    output logic [alu_pkg::word_width-1:0]  res,
    output logic                            carry_out,
    output logic                            all_ones
);

    alu_slice_if lo_bus ();
    alu_slice_if hi_bus ();

    alu_pkg::alu_ctrl_u lo_ctrl;
    alu_pkg::alu_ctrl_u hi_ctrl;
    logic               shift_op;
    logic               lo_ones;
    logic               hi_ones;

    assign shift_op = (cmd.ctrl.sel == 2'b11);

    // on a shift the low slice takes bit 0 of the high nibble as its shift-in
    always_comb begin
        lo_ctrl = cmd;
        if (shift_op) begin
            lo_ctrl.ctrl.carry_in = d2[alu_pkg::slice_width];
        end
    end

    // arithmetic carry moves up from the low slice, logic ops mask it anyway
    always_comb begin
        hi_ctrl = cmd;
        if (!shift_op) begin
            hi_ctrl.ctrl.carry_in = lo_bus.ret.carry_out;
        end
    end

    assign lo_bus.args = '{
        d1:   d1[alu_pkg::slice_width-1:0],
        d2:   d2[alu_pkg::slice_width-1:0],
        ctrl: lo_ctrl
    };

    assign hi_bus.args = '{
        d1:   d1[alu_pkg::word_width-1:alu_pkg::slice_width],
        d2:   d2[alu_pkg::word_width-1:alu_pkg::slice_width],
        ctrl: hi_ctrl
    };

    alu_slice u_lo_slice (
        .bus (lo_bus)
    );

    alu_slice u_hi_slice (
        .bus (hi_bus)
    );

    assign res       = {hi_bus.ret.res, lo_bus.ret.res};
    assign carry_out = hi_bus.ret.carry_out; // word carry comes from the top slice

    // after COMP an all-ones word means the operands were equal
    assign lo_ones  = &lo_bus.ret.res;
    assign hi_ones  = &hi_bus.ret.res;
    assign all_ones = lo_ones & hi_ones;

endmodule

// ==== hw/alu_top.sv ====
module alu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  logic [4:0]                     cmd,
    input  logic [alu_pkg::word_width-1:0] d1,
    input  logic [alu_pkg::word_width-1:0] d2,
    output logic                           out_valid,
    output logic [alu_pkg::word_width-1:0] res,
    output logic                           carry_out,
    output logic                           all_ones
);

    alu_pkg::alu_ctrl_u             cmd_word;
    logic [alu_pkg::word_width-1:0] alu_res;
    logic                           alu_carry_out;
    logic                           alu_all_ones;

    assign cmd_word = cmd; // raw control bits seen through the union

    alu_word u_alu_word (
        .cmd       (cmd_word),
        .d1        (d1),
        .d2        (d2),
        .res       (alu_res),
        .carry_out (alu_carry_out),
        .all_ones  (alu_all_ones)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            res       <= '0;
            carry_out <= 1'b0;
            all_ones  <= 1'b0;
        end else begin
            out_valid <= in_valid; // one-cycle pulse, one cycle after the request
            if (in_valid) begin
                res       <= alu_res; // outputs hold until the next valid operation
                carry_out <= alu_carry_out;
                all_ones  <= alu_all_ones;
            end
        end
    end

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    // reset is held for ten cycles and let go on a falling edge
    initial begin
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== verif/alu_tb.sv ====
module alu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 10;
    localparam int reset_cycles = 10;
    localparam int rand_pairs   = 200;
    localparam int equal_pairs  = 16;
    localparam int logic_pairs  = 100;
    localparam int shift_pairs  = 100;
    localparam int burst_ops    = 16;
    localparam int add_ops      = 16 * 18 * 2 + 12; // strided sweep plus corners for each carry-in
    localparam int num_ops      = 1 + add_ops + 2 * (rand_pairs + equal_pairs)
                                + 4 * logic_pairs + 2 * shift_pairs + burst_ops;
    localparam int timeout_ns   = (num_ops * 3 + reset_cycles + 50) * clk_period;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic [4:0] cmd;
    logic [7:0] d1;
    logic [7:0] d2;
    logic       out_valid;
    logic [7:0] res;
    logic       carry_out;
    logic       all_ones;

    integer seed = 99516;

    alu_pkg::alu_cmd_e op_list[8] = '{alu_pkg::ADD, alu_pkg::SUB, alu_pkg::XOR, alu_pkg::XNOR,
                                      alu_pkg::COMP, alu_pkg::AND, alu_pkg::OR, alu_pkg::RSHFT};

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    alu_top dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .cmd       (cmd),
        .d1        (d1),
        .d2        (d2),
        .out_valid (out_valid),
        .res       (res),
        .carry_out (carry_out),
        .all_ones  (all_ones)
    );

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    // returns {carry known, carry, result}; carry is only defined for arithmetic
    function automatic logic [9:0] reference_alu(input alu_pkg::alu_cmd_e op, input logic cin,
                                                 input logic [7:0] a, input logic [7:0] b);
        logic [8:0] sum;
        logic       known;
        logic       carry;
        logic [7:0] r;
        sum   = '0;
        known = 1'b1;
        carry = 1'b0;
        r     = '0;
        case (op)
            alu_pkg::ADD: begin
                sum   = {1'b0, a} + {1'b0, b} + {8'b0, cin};
                r     = sum[7:0];
                carry = sum[8];
            end
            alu_pkg::SUB: begin
                r     = a - b;
                carry = (a >= b); // no borrow
            end
            alu_pkg::COMP: begin
                r     = a - b - 8'd1;
                carry = (a > b);
            end
            alu_pkg::XOR:   r = a ^ b;
            alu_pkg::XNOR:  r = ~(a ^ b);
            alu_pkg::AND:   r = a & b;
            alu_pkg::OR:    r = a | b;
            default: begin
                r     = {cin, b[7:1]}; // shift-in bit lands in the MSB
                known = 1'b0;
            end
        endcase
        if (op != alu_pkg::ADD && op != alu_pkg::SUB && op != alu_pkg::COMP) begin
            known = 1'b0;
        end
        return {known, carry, r};
    endfunction

    task automatic drive_inputs(input alu_pkg::alu_cmd_e op, input logic cin,
                                input logic [7:0] a, input logic [7:0] b);
        in_valid = 1'b1;
        cmd      = 5'(op) | {cin, 4'b0000}; // top bit of the control word is carry_in
        d1       = a;
        d2       = b;
    endtask

    task automatic check_outputs(input logic [9:0] expected);
        check_eq("res", res, expected[7:0]);
        if (expected[9]) begin
            check_eq("carry_out", carry_out, expected[8]);
        end
        check_eq("all_ones", all_ones, &expected[7:0]);
    endtask

    task automatic apply_op(input alu_pkg::alu_cmd_e op, input logic cin,
                            input logic [7:0] a, input logic [7:0] b);
        logic [9:0] expected;
        int         cycles;
        expected = reference_alu(op, cin, a, b);
        cycles   = 0;
        @(negedge clk);
        check_eq("out_valid", out_valid, 0); // any earlier pulse is gone after one cycle
        drive_inputs(op, cin, a, b);
        do begin
            @(negedge clk);
            in_valid = 1'b0;
            cycles++;
        end while (!out_valid && cycles < 4);
        if (!out_valid) begin
            $display("out_valid never rose after a %s operation", op.name());
            stop_on_error();
        end else begin
            check_eq("out_valid latency", cycles, 1);
            check_outputs(expected);
        end
    endtask

    task automatic run_reset_checks();
        @(negedge clk);
        repeat (8) begin
            @(negedge clk);
            check_eq("out_valid", out_valid, 0);
            check_eq("res", res, 0);
            check_eq("carry_out", carry_out, 0);
            check_eq("all_ones", all_ones, 0);
        end
        wait (rst == 1'b0);
        @(negedge clk);
        check_eq("out_valid", out_valid, 0); // first cycle out of reset
        check_eq("res", res, 0);
        check_eq("carry_out", carry_out, 0);
        check_eq("all_ones", all_ones, 0);
        apply_op(alu_pkg::ADD, 1'b0, 8'h12, 8'h34);
    endtask

    task automatic sweep_add();
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 256; a += 17) begin
                for (int b = 0; b < 256; b += 15) begin
                    apply_op(alu_pkg::ADD, 1'(c), 8'(a), 8'(b));
                end
            end
            // corners that push a carry across the nibble boundary
            apply_op(alu_pkg::ADD, 1'(c), 8'h00, 8'h00);
            apply_op(alu_pkg::ADD, 1'(c), 8'hff, 8'hff);
            apply_op(alu_pkg::ADD, 1'(c), 8'hff, 8'h01);
            apply_op(alu_pkg::ADD, 1'(c), 8'h0f, 8'h01);
            apply_op(alu_pkg::ADD, 1'(c), 8'h0f, 8'hf0);
            apply_op(alu_pkg::ADD, 1'(c), 8'h80, 8'h80);
        end
    endtask

    task automatic sub_comp_cases();
        logic [7:0] a;
        logic [7:0] b;
        for (int i = 0; i < rand_pairs; i++) begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            apply_op(alu_pkg::SUB, 1'b0, a, b);
            apply_op(alu_pkg::COMP, 1'b0, a, b);
        end
        for (int i = 0; i < equal_pairs; i++) begin
            a = 8'($random(seed));
            apply_op(alu_pkg::SUB, 1'b0, a, a);
            apply_op(alu_pkg::COMP, 1'b0, a, a); // equal operands give all ones
        end
    endtask

    task automatic logic_cases();
        logic [7:0] a;
        logic [7:0] b;
        for (int i = 0; i < logic_pairs; i++) begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            apply_op(alu_pkg::XOR, 1'b0, a, b);
            apply_op(alu_pkg::XNOR, 1'b0, a, b);
            apply_op(alu_pkg::AND, 1'b0, a, b);
            apply_op(alu_pkg::OR, 1'b0, a, b);
        end
    endtask

    task automatic shift_cases();
        for (int i = 0; i < shift_pairs; i++) begin
            apply_op(alu_pkg::RSHFT, 1'b0, 8'($random(seed)), 8'($random(seed)));
            apply_op(alu_pkg::RSHFT, 1'b1, 8'($random(seed)), 8'($random(seed)));
        end
    endtask

    task automatic back_to_back_ops(input int count);
        logic [9:0]        expected_q[$];
        alu_pkg::alu_cmd_e op;
        logic              cin;
        logic [7:0]        a;
        logic [7:0]        b;
        @(negedge clk);
        for (int k = 0; k <= count; k++) begin
            if (k > 0) begin
                check_eq("out_valid", out_valid, 1); // result of the operation one cycle back
                check_outputs(expected_q.pop_front());
            end
            if (k < count) begin
                op  = op_list[$unsigned($random(seed)) % 8];
                cin = (op == alu_pkg::ADD || op == alu_pkg::RSHFT) ? 1'($random(seed)) : 1'b0;
                a   = 8'($random(seed));
                b   = 8'($random(seed));
                expected_q.push_back(reference_alu(op, cin, a, b));
                drive_inputs(op, cin, a, b);
                @(negedge clk);
            end else begin
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        check_eq("out_valid", out_valid, 0);
    endtask

    initial begin
        #(timeout_ns);
        $display("the run did not finish within %0d ns and was stopped", timeout_ns);
        stop_on_error();
    end

    initial begin
        in_valid = 1'b0;
        cmd      = '0;
        d1       = '0;
        d2       = '0;
        run_reset_checks();
        sweep_add();
        sub_comp_cases();
        logic_cases();
        shift_cases();
        back_to_back_ops(burst_ops);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/alu_pkg.sv
hw/alu_slice_if.sv
hw/full_adder.sv
hw/carry_gen.sv
hw/alu_slice.sv
hw/alu_word.sv
hw/alu_top.sv
verif/tb_clock.sv
verif/alu_tb.sv

// ==== Makefile ====
TOP := alu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "FAIL: run ended early"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
